// File: dv/eeprom_model.sv
`include "eeprom_config.svh"

module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic present     // low: never acknowledges
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {M_IDLE, M_CTRL, M_ADDR, M_DATA, M_SEND} mstate_e;

    logic [`EE_DATA_W-1:0] mem [1 << `EE_ADDR_W];
    mstate_e               state;
    mstate_e               nxt;        // state after the ack slot
    logic [`EE_DATA_W-1:0] sh;
    logic [2:0]            page;
    logic [`EE_DATA_W-1:0] word;
    int                    bit_n;      // SCL highs seen in this byte
    logic                  drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            mem[i] = i[7:0] ^ {i[10:8], 5'b01101};
        state     = M_IDLE;
        nxt       = M_IDLE;
        sh        = '0;
        page      = '0;
        word      = '0;
        bit_n     = 0;
        drive_low = 1'b0;
    end

    // decide the ack for a byte just clocked in
    task take_byte();
        drive_low = 1'b0;
        nxt       = M_IDLE;
        case (state)
            M_CTRL:
            begin
                if (sh[7:4] == `EE_DEV_CODE)
                begin
                    page      = sh[3:1];
                    nxt       = sh[0] ? M_SEND : M_ADDR;
                    drive_low = 1'b1;
                end
            end
            M_ADDR:
            begin
                word      = sh;
                nxt       = M_DATA;
                drive_low = 1'b1;
            end
            M_DATA:
            begin
                mem[{page, word}] = sh;   // internal write done at once
                word              = word + 1'b1;
                nxt               = M_DATA;
                drive_low         = 1'b1;
            end
            default: ;
        endcase
        if (!present)
        begin
            drive_low = 1'b0;
            nxt       = M_IDLE;
        end
    endtask

    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state = M_CTRL;   // start or repeated start
            bit_n = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = M_IDLE;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state != M_IDLE)
        begin
            if (bit_n < 8 && state != M_SEND)
                sh = {sh[6:0], sda};
            bit_n = bit_n + 1;
        end
    end

    always @(negedge scl)
    begin
        if (state != M_IDLE)
        begin
            if (bit_n == 8)
            begin
                if (state == M_SEND)
                    drive_low = 1'b0;   // master acks here
                else
                    take_byte();
            end
            else if (bit_n == 9)
            begin
                bit_n     = 0;
                drive_low = 1'b0;
                // single reads only, so a sent byte ends the access
                state = (state == M_SEND) ? M_IDLE : nxt;
                if (state == M_SEND)
                begin
                    sh        = mem[{page, word}];
                    drive_low = ~sh[7];
                end
            end
            else if (state == M_SEND)
                drive_low = ~sh[7 - bit_n];
        end
    end

endmodule

// File: dv/tb_eeprom_subsystem.sv
`include "eeprom_config.svh"

module tb_eeprom_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    import host_pkg::*;

    localparam int N_ROWS_MAX  = 16;
    localparam int ACK_TIMEOUT = 2000;   // CLK cycles per row
    localparam int MEM_SIZE    = 1 << `EE_ADDR_W;

    logic                  CLK;
    logic                  RESET;
    logic                  a_wr;
    logic                  a_rd;
    logic [`EE_ADDR_W-1:0] a_addr;
    logic [`EE_DATA_W-1:0] a_wdata;
    logic [`EE_DATA_W-1:0] a_rdata;
    logic                  a_ack;
    logic                  a_nak;
    logic                  b_wr;
    logic                  b_rd;
    logic [`EE_ADDR_W-1:0] b_addr;
    logic [`EE_DATA_W-1:0] b_wdata;
    logic [`EE_DATA_W-1:0] b_rdata;
    logic                  b_ack;
    logic                  b_nak;
    logic                  scl;
    wire                   sda;
    logic                  present;

    logic [1:0]            row_hosts [N_ROWS_MAX];   // bit 0 host a, bit 1 host b
    op_e                   row_op [N_ROWS_MAX];
    logic [`EE_ADDR_W-1:0] row_addr [N_ROWS_MAX][2];
    logic [`EE_DATA_W-1:0] row_data [N_ROWS_MAX][2];
    logic                  row_present [N_ROWS_MAX];
    logic [`EE_DATA_W-1:0] row_exp_rdata [N_ROWS_MAX][2];
    logic                  row_exp_nak [N_ROWS_MAX][2];
    int                    row_first [N_ROWS_MAX];   // host acked first, dual rows
    int                    n_rows;
    logic [`EE_DATA_W-1:0] shadow [MEM_SIZE];
    int                    error_count;
    int                    timeout_count;
    int                    seed_ret;

    pullup (sda);

    eeprom_subsystem eeprom_subsystem_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .a_wr    (a_wr),
        .a_rd    (a_rd),
        .a_addr  (a_addr),
        .a_wdata (a_wdata),
        .a_rdata (a_rdata),
        .a_ack   (a_ack),
        .a_nak   (a_nak),
        .b_wr    (b_wr),
        .b_rd    (b_rd),
        .b_addr  (b_addr),
        .b_wdata (b_wdata),
        .b_rdata (b_rdata),
        .b_ack   (b_ack),
        .b_nak   (b_nak),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model eeprom_model_inst (
        .scl     (scl),
        .sda     (sda),
        .present (present)
    );

    always #4 CLK = ~CLK;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic add_row(input logic [1:0] hosts, input op_e op,
                           input logic [`EE_ADDR_W-1:0] addr,
                           input logic [`EE_DATA_W-1:0] data, input logic present_in);
        row_hosts[n_rows]   = hosts;
        row_op[n_rows]      = op;
        row_addr[n_rows][0] = addr;
        row_data[n_rows][0] = data;
        // mirrored address and data for b when both strobe
        row_addr[n_rows][1] = (hosts == 2'b11) ? ~addr : addr;
        row_data[n_rows][1] = (hosts == 2'b11) ? ~data : data;
        row_present[n_rows] = present_in;
        n_rows++;
    endtask

    task automatic build_expected();
        int last;
        last = 1;   // arbiter starts pointing at b
        for (int i = 0; i < MEM_SIZE; i++)
            shadow[i] = i[7:0] ^ {i[10:8], 5'b01101};
        for (int r = 0; r < n_rows; r++)
        begin
            for (int h = 0; h < 2; h++)
            begin
                row_exp_nak[r][h]   = !row_present[r];
                row_exp_rdata[r][h] = '1;   // released line reads high
                if (row_hosts[r][h] && row_present[r])
                begin
                    if (row_op[r] == OP_WRITE)
                        shadow[row_addr[r][h]] = row_data[r][h];
                    else
                        row_exp_rdata[r][h] = shadow[row_addr[r][h]];
                end
            end
            // both pending: the other host first, last grant ends unchanged
            if (row_hosts[r] == 2'b11)
                row_first[r] = 1 - last;
            else
                last = row_hosts[r][1] ? 1 : 0;
        end
    endtask

    task automatic take_result(input int r, input int h, input logic [7:0] rdata,
                               input logic nak, inout logic [1:0] seen);
        if (!row_hosts[r][h] || seen[h])
        begin
            $display("unexpected ack from host %s in row %0d", h ? "b" : "a", r);
            error_count++;
        end
        else
        begin
            if (row_hosts[r] == 2'b11 && seen == 2'b00)
                check_value("first acked host", h, row_first[r]);
            seen[h] = 1'b1;
            check_value(h ? "b_nak" : "a_nak", nak, row_exp_nak[r][h]);
            if (row_op[r] == OP_READ)
                check_value(h ? "b_rdata" : "a_rdata", rdata, row_exp_rdata[r][h]);
        end
    endtask

    task automatic apply_row(input int r);
        logic [1:0] seen;
        int         cycles;
        seen   = 2'b00;
        cycles = 0;
        @(negedge CLK);
        present = row_present[r];
        a_addr  = row_addr[r][0];
        a_wdata = row_data[r][0];
        b_addr  = row_addr[r][1];
        b_wdata = row_data[r][1];
        a_wr    = row_hosts[r][0] && row_op[r] == OP_WRITE;
        a_rd    = row_hosts[r][0] && row_op[r] == OP_READ;
        b_wr    = row_hosts[r][1] && row_op[r] == OP_WRITE;
        b_rd    = row_hosts[r][1] && row_op[r] == OP_READ;
        @(negedge CLK);
        a_wr = 1'b0;
        a_rd = 1'b0;
        b_wr = 1'b0;
        b_rd = 1'b0;
        while (seen != row_hosts[r] && cycles < ACK_TIMEOUT)
        begin
            @(negedge CLK);
            cycles++;
            if (a_ack)
                take_result(r, 0, a_rdata, a_nak, seen);
            if (b_ack)
                take_result(r, 1, b_rdata, b_nak, seen);
        end
        if (seen != row_hosts[r])
        begin
            $display("timeout: row %0d got no ack within %0d cycles", r, ACK_TIMEOUT);
            timeout_count++;
        end
    endtask

    initial
    begin
        CLK           = 1'b0;
        RESET         = 1'b1;
        a_wr          = 1'b0;
        a_rd          = 1'b0;
        a_addr        = '0;
        a_wdata       = '0;
        b_wr          = 1'b0;
        b_rd          = 1'b0;
        b_addr        = '0;
        b_wdata       = '0;
        present       = 1'b1;
        error_count   = 0;
        timeout_count = 0;
        n_rows        = 0;
        seed_ret      = $urandom(32'h5cd1b348);

        // contention straight after reset, a first
        add_row(2'b11, OP_WRITE, 11'h123, 8'($urandom), 1'b1);
        add_row(2'b01, OP_WRITE, 11'h07f, 8'($urandom), 1'b1);
        add_row(2'b11, OP_READ,  11'h123, 8'($urandom), 1'b1);   // now b first
        add_row(2'b01, OP_READ,  11'h07f, 8'($urandom), 1'b1);
        // same word address, page bits differ, low bits tag the page
        add_row(2'b01, OP_WRITE, 11'h05a, {5'($urandom), 3'd0}, 1'b1);
        add_row(2'b10, OP_WRITE, 11'h15a, {5'($urandom), 3'd1}, 1'b1);
        add_row(2'b01, OP_WRITE, 11'h35a, {5'($urandom), 3'd3}, 1'b1);
        add_row(2'b10, OP_WRITE, 11'h75a, {5'($urandom), 3'd7}, 1'b1);
        add_row(2'b10, OP_READ,  11'h05a, 8'($urandom), 1'b1);
        add_row(2'b01, OP_READ,  11'h15a, 8'($urandom), 1'b1);
        add_row(2'b10, OP_READ,  11'h35a, 8'($urandom), 1'b1);
        add_row(2'b01, OP_READ,  11'h75a, 8'($urandom), 1'b1);
        // device absent
        add_row(2'b01, OP_WRITE, 11'h07f, 8'($urandom), 1'b0);
        add_row(2'b10, OP_READ,  11'h07f, 8'($urandom), 1'b0);
        add_row(2'b01, OP_READ,  11'h07f, 8'($urandom), 1'b1);
        add_row(2'b10, OP_READ,  11'h2c3, 8'($urandom), 1'b1);   // untouched location
        build_expected();

        repeat (3) @(negedge CLK);
        RESET = 1'b0;

        // idle bus, no acks
        repeat (6)
        begin
            @(negedge CLK);
            check_value("scl", scl, 1'b1);
            check_value("sda", sda, 1'b1);
            check_value("a_ack", a_ack, 1'b0);
            check_value("b_ack", b_ack, 1'b0);
        end

        for (int r = 0; r < n_rows; r++)
        begin
            apply_row(r);
            if (timeout_count != 0)
                break;
        end

        @(negedge CLK);
        check_value("scl", scl, 1'b1);
        check_value("sda", sda, 1'b1);

        $display("errors: %0d failed checks, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
src/host_pkg.sv
src/serial_pkg.sv
src/eeprom_req_if.sv
src/req_arbiter.sv
src/serial_eeprom_master.sv
src/eeprom_subsystem.sv
dv/eeprom_model.sv
dv/tb_eeprom_subsystem.sv

// File: src/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// 24C16 style part, 2 Kbyte
`define EE_ADDR_W 11
`define EE_DATA_W 8

// control byte prefix
`define EE_DEV_CODE 4'b1010

// CLK cycles per SCL half period
`define EE_SCL_HALF 2

`endif

// File: src/eeprom_req_if.sv
`include "eeprom_config.svh"

interface eeprom_req_if;
    import host_pkg::*;

    logic                  start;   // one cycle, master idle
    op_e                   op;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic [`EE_DATA_W-1:0] rdata;
    logic                  done;    // one cycle, result valid
    logic                  nak;

    modport arb (
        output start, op, addr, wdata,
        input  rdata, done, nak
    );

    modport mst (
        input  start, op, addr, wdata,
        output rdata, done, nak
    );

endinterface

// File: src/eeprom_subsystem.sv
`include "eeprom_config.svh"

module eeprom_subsystem (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  a_wr,
    input  logic                  a_rd,
    input  logic [`EE_ADDR_W-1:0] a_addr,
    input  logic [`EE_DATA_W-1:0] a_wdata,
    output logic [`EE_DATA_W-1:0] a_rdata,
    output logic                  a_ack,
    output logic                  a_nak,
    input  logic                  b_wr,
    input  logic                  b_rd,
    input  logic [`EE_ADDR_W-1:0] b_addr,
    input  logic [`EE_DATA_W-1:0] b_wdata,
    output logic [`EE_DATA_W-1:0] b_rdata,
    output logic                  b_ack,
    output logic                  b_nak,
    output logic                  scl,
    inout  wire                   sda
);

    logic sda_low;

    eeprom_req_if req_if_inst ();

    req_arbiter arbiter_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .a_wr    (a_wr),
        .a_rd    (a_rd),
        .b_wr    (b_wr),
        .b_rd    (b_rd),
        .a_addr  (a_addr),
        .b_addr  (b_addr),
        .a_wdata (a_wdata),
        .b_wdata (b_wdata),
        .a_rdata (a_rdata),
        .b_rdata (b_rdata),
        .a_ack   (a_ack),
        .a_nak   (a_nak),
        .b_ack   (b_ack),
        .b_nak   (b_nak),
        .bus     (req_if_inst.arb)
    );

    serial_eeprom_master master_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .bus     (req_if_inst.mst),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda)
    );

    // open drain, pulled up off chip
    assign sda = sda_low ? 1'b0 : 1'bz;

endmodule

// File: src/host_pkg.sv
package host_pkg;

    // one host operation per request
    typedef enum logic {
        OP_WRITE,
        OP_READ
    } op_e;

    // which host owns the bus
    typedef enum logic {
        CLIENT_A,
        CLIENT_B
    } client_e;

endpackage

// File: src/req_arbiter.sv
`include "eeprom_config.svh"

module req_arbiter (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  a_wr,
    input  logic                  a_rd,
    input  logic                  b_wr,
    input  logic                  b_rd,
    input  logic [`EE_ADDR_W-1:0] a_addr,
    input  logic [`EE_ADDR_W-1:0] b_addr,
    input  logic [`EE_DATA_W-1:0] a_wdata,
    input  logic [`EE_DATA_W-1:0] b_wdata,
    output logic [`EE_DATA_W-1:0] a_rdata,
    output logic [`EE_DATA_W-1:0] b_rdata,
    output logic                  a_ack,
    output logic                  a_nak,
    output logic                  b_ack,
    output logic                  b_nak,
    eeprom_req_if.arb             bus
);
    import host_pkg::*;

    logic [1:0]            wr_s;
    logic [1:0]            rd_s;
    logic [`EE_ADDR_W-1:0] addr_s [2];
    logic [`EE_DATA_W-1:0] data_s [2];
    logic [1:0]            full;          // one pending slot per host
    op_e                   slot_op [2];
    logic [`EE_ADDR_W-1:0] slot_addr [2];
    logic [`EE_DATA_W-1:0] slot_data [2];
    logic                  busy;
    client_e               last_grant;    // also the current owner while busy
    client_e               pick;

    assign wr_s = {b_wr, a_wr};
    assign rd_s = {b_rd, a_rd};
    assign addr_s[CLIENT_A] = a_addr;
    assign addr_s[CLIENT_B] = b_addr;
    assign data_s[CLIENT_A] = a_wdata;
    assign data_s[CLIENT_B] = b_wdata;

    // round robin on contention
    always_comb
    begin
        if (full[CLIENT_A] && full[CLIENT_B])
        begin
            if (last_grant == CLIENT_A)
                pick = CLIENT_B;
            else
                pick = CLIENT_A;
        end
        else if (full[CLIENT_A])
            pick = CLIENT_A;
        else
            pick = CLIENT_B;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            full <= '0;
        else
        begin
            for (int i = 0; i < 2; i++)
            begin
                if (full[i])
                begin
                    if (bus.done && last_grant == client_e'(i))
                        full[i] <= 1'b0;
                end
                else if (wr_s[i] || rd_s[i])
                    full[i] <= 1'b1;   // new strobes ignored while pending
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (!full[i] && (wr_s[i] || rd_s[i]))
            begin
                if (wr_s[i])
                    slot_op[i] <= OP_WRITE;   // write wins a double strobe
                else
                    slot_op[i] <= OP_READ;
                slot_addr[i] <= addr_s[i];
                slot_data[i] <= data_s[i];
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy       <= 1'b0;
            bus.start  <= 1'b0;
            last_grant <= CLIENT_B;   // a wins the first contention
        end
        else
        begin
            bus.start <= 1'b0;
            if (bus.done)
                busy <= 1'b0;
            else if (!busy && full != 2'b00)
            begin
                busy       <= 1'b1;
                bus.start  <= 1'b1;
                last_grant <= pick;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && full != 2'b00)
        begin
            bus.op    <= slot_op[pick];
            bus.addr  <= slot_addr[pick];
            bus.wdata <= slot_data[pick];
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            a_ack <= 1'b0;
            b_ack <= 1'b0;
        end
        else
        begin
            a_ack <= bus.done && last_grant == CLIENT_A;
            b_ack <= bus.done && last_grant == CLIENT_B;
        end
    end

    // results held until that host's next ack
    always_ff @(posedge CLK)
    begin
        if (bus.done && last_grant == CLIENT_A)
        begin
            a_rdata <= bus.rdata;
            a_nak   <= bus.nak;
        end
        if (bus.done && last_grant == CLIENT_B)
        begin
            b_rdata <= bus.rdata;
            b_nak   <= bus.nak;
        end
    end

endmodule

// File: src/serial_eeprom_master.sv
`include "eeprom_config.svh"

module serial_eeprom_master (
    input  logic         CLK,
    input  logic         RESET,
    eeprom_req_if.mst    bus,
    output logic         scl,
    output logic         sda_low,   // pulls the line low when set
    input  logic         sda_in
);
    import host_pkg::*;
    import serial_pkg::*;

    localparam int CNT_W = ($clog2(`EE_SCL_HALF) > 0) ? $clog2(`EE_SCL_HALF) : 1;
    localparam int BIT_W = $clog2(`EE_DATA_W);

    seq_e                  seq;
    seq_e                  after_ack;
    phase_e                phase;
    logic [CNT_W-1:0]      cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [`EE_DATA_W-1:0] sh;
    op_e                   op_q;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;
    logic [`EE_DATA_W-1:0] ctrl_wr;
    logic [`EE_DATA_W-1:0] ctrl_rd;
    logic                  tick;
    logic                  set_lo;
    logic                  set_hi;
    logic                  rise;
    logic                  fall;
    logic                  in_byte;
    logic                  receiving;
    logic                  ack_end;
    logic                  got_nak;

    // page bits ride in the control byte
    assign ctrl_wr = {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:`EE_DATA_W], 1'b0};
    assign ctrl_rd = {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:`EE_DATA_W], 1'b1};

    assign tick   = (cnt == CNT_W'(`EE_SCL_HALF - 1));
    assign set_lo = (cnt == '0) && !scl;   // one CLK after SCL fell
    assign set_hi = (cnt == '0) && scl;    // one CLK after SCL rose
    assign rise   = tick && !scl;
    assign fall   = tick && scl;

    assign in_byte   = seq inside {CTRL_WR, ADDR, DATA_WR, CTRL_RD, DATA_RD};
    assign receiving = (seq == DATA_RD);
    assign ack_end   = in_byte && fall && phase == ACK_SLOT;
    assign got_nak   = ack_end && !receiving && sda_in;

    assign bus.done = (seq == DONE);

    always_comb
    begin
        case (seq)
            CTRL_WR: after_ack = ADDR;
            ADDR:
            begin
                if (op_q == OP_WRITE)
                    after_ack = DATA_WR;
                else
                    after_ack = RESTART;
            end
            CTRL_RD: after_ack = DATA_RD;
            default: after_ack = STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            seq     <= IDLE;
            phase   <= BIT;
            bit_cnt <= BIT_W'(`EE_DATA_W - 1);
            cnt     <= '0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            bus.nak <= 1'b0;
        end
        else
        begin
            if (seq == IDLE || seq == DONE || tick)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            case (seq)
                IDLE:
                begin
                    if (bus.start)
                    begin
                        seq     <= START;
                        sda_low <= 1'b1;   // SDA falls, SCL still high
                        bus.nak <= 1'b0;
                    end
                end
                START:
                begin
                    if (tick)
                    begin
                        scl     <= 1'b0;
                        seq     <= CTRL_WR;
                        phase   <= BIT;
                        bit_cnt <= BIT_W'(`EE_DATA_W - 1);
                    end
                end
                CTRL_WR, ADDR, DATA_WR, CTRL_RD, DATA_RD:
                begin
                    if (set_lo)
                        sda_low <= (phase == BIT && !receiving) ? ~sh[`EE_DATA_W-1] : 1'b0;
                    if (rise)
                        scl <= 1'b1;
                    if (fall)
                    begin
                        scl <= 1'b0;
                        if (phase == BIT)
                        begin
                            if (bit_cnt == '0)
                                phase <= ACK_SLOT;
                            else
                                bit_cnt <= bit_cnt - 1'b1;
                        end
                        else
                        begin
                            phase   <= BIT;
                            bit_cnt <= BIT_W'(`EE_DATA_W - 1);
                            if (got_nak)
                            begin
                                bus.nak <= 1'b1;
                                seq     <= STOP;
                            end
                            else
                                seq <= after_ack;
                        end
                    end
                end
                RESTART:
                begin
                    if (set_lo)
                        sda_low <= 1'b0;
                    if (rise)
                        scl <= 1'b1;
                    if (set_hi)
                        sda_low <= 1'b1;   // repeated start
                    if (fall)
                    begin
                        scl     <= 1'b0;
                        seq     <= CTRL_RD;
                        phase   <= BIT;
                        bit_cnt <= BIT_W'(`EE_DATA_W - 1);
                    end
                end
                STOP:
                begin
                    if (set_lo)
                        sda_low <= 1'b1;
                    if (rise)
                        scl <= 1'b1;
                    if (set_hi)
                        sda_low <= 1'b0;   // SDA rises with SCL high
                    if (fall)
                        seq <= DONE;       // SCL left high
                end
                DONE:
                    seq <= IDLE;
                default:
                    seq <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (seq == IDLE && bus.start)
        begin
            op_q    <= bus.op;
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
        end

        if (seq == START && tick)
            sh <= ctrl_wr;
        else if (seq == RESTART && fall)
            sh <= ctrl_rd;
        else if (in_byte && fall)
        begin
            // same shift for both directions, MSB first
            if (phase == BIT)
                sh <= {sh[`EE_DATA_W-2:0], sda_in};
            else if (after_ack == ADDR)
                sh <= addr_q[`EE_DATA_W-1:0];
            else if (after_ack == DATA_WR)
                sh <= wdata_q;
        end

        if (got_nak)
            bus.rdata <= '1;   // released line reads high
        else if (ack_end && receiving)
            bus.rdata <= sh;
    end

endmodule

// File: src/serial_pkg.sv
package serial_pkg;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR,
        DATA_WR,
        RESTART,     // repeated start of a random read
        CTRL_RD,
        DATA_RD,
        STOP,
        DONE
    } seq_e;

    // data bits, then the ninth clock
    typedef enum logic {
        BIT,
        ACK_SLOT
    } phase_e;

endpackage
